//--- common/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// datapath width
`define XLEN 32

// register file geometry
`define REG_AW 5
`define NUM_REGS 32

`endif

//--- common/ex_pkg.sv
package ex_pkg;

  // --------------------
  // alu operations
  // --------------------
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,     // also drives the set unit
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI,
    OP_PASS_A,
    OP_PASS_B
  } alu_op_t;

  // which unit feeds the result bus
  typedef enum logic {
    RES_ALU,
    RES_SET
  } res_sel_t;

  // --------------------
  // operand forwarding
  // --------------------
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_FROM_EXMEM,   // producer one ahead
    FWD_FROM_MEMWB    // producer two ahead
  } fwd_t;

endpackage

//--- design/decode.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module decode (
  input  logic [31:0]         instr,
  output logic [`REG_AW-1:0]  rs,
  output logic [`REG_AW-1:0]  rt,
  output logic                rs_used,
  output logic [`REG_AW-1:0]  dest_reg,
  output logic                dest_reg_valid,
  output logic [`XLEN-1:0]    imm,
  output logic                imm_valid,
  output logic [4:0]          shamt,
  output ex_pkg::alu_op_t     alu_op,
  output ex_pkg::res_sel_t    alu_res_sel,
  output logic                alu_set_u,
  output logic                store_inst
);

  typedef enum logic [5:0] {
    OPC_SPECIAL = 6'h00, OPC_ADDI = 6'h08, OPC_ADDIU = 6'h09, OPC_SLTI = 6'h0a,
    OPC_SLTIU = 6'h0b, OPC_ANDI = 6'h0c, OPC_ORI = 6'h0d, OPC_XORI = 6'h0e,
    OPC_LUI = 6'h0f, OPC_SW = 6'h2b
  } opc_t;

  typedef enum logic [5:0] {
    FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_SLLV = 6'h04,
    FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_ADD = 6'h20, FN_ADDU = 6'h21,
    FN_SUB = 6'h22, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25,
    FN_XOR = 6'h26, FN_NOR = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
  } funct_t;

  opc_t               opc;
  funct_t             funct;
  logic [`REG_AW-1:0] rd;
  logic               sign_ext;
  logic               use_rd;   // r-type writes rd
  logic               writes;

  assign opc   = opc_t'(instr[31:26]);
  assign funct = funct_t'(instr[5:0]);
  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rd    = instr[15:11];
  assign shamt = instr[10:6];

  assign imm = sign_ext ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

  assign dest_reg       = use_rd ? rd : rt;
  assign dest_reg_valid = writes && (dest_reg != '0);  // r0 never written

  always_comb begin
    alu_op      = ex_pkg::OP_ADD;
    alu_res_sel = ex_pkg::RES_ALU;
    alu_set_u   = 1'b0;
    imm_valid   = 1'b0;
    sign_ext    = 1'b1;
    rs_used     = 1'b1;
    use_rd      = 1'b0;
    writes      = 1'b0;
    store_inst  = 1'b0;

    case (opc)
      OPC_SPECIAL: begin
        use_rd = 1'b1;
        writes = 1'b1;
        case (funct)
          FN_ADD, FN_ADDU: alu_op = ex_pkg::OP_ADD;
          FN_SUB, FN_SUBU: alu_op = ex_pkg::OP_SUB;
          FN_AND:          alu_op = ex_pkg::OP_AND;
          FN_OR:           alu_op = ex_pkg::OP_OR;
          FN_XOR:          alu_op = ex_pkg::OP_XOR;
          FN_NOR:          alu_op = ex_pkg::OP_NOR;
          FN_SLLV:         alu_op = ex_pkg::OP_SLL;   // amount from rs
          FN_SRLV:         alu_op = ex_pkg::OP_SRL;
          FN_SRAV:         alu_op = ex_pkg::OP_SRA;
          FN_SLT, FN_SLTU: begin
            alu_op      = ex_pkg::OP_SUB;
            alu_res_sel = ex_pkg::RES_SET;
            alu_set_u   = (funct == FN_SLTU);
          end
          FN_SLL, FN_SRL, FN_SRA: begin
            rs_used = 1'b0;   // amount from shamt
            case (funct)
              FN_SLL:  alu_op = ex_pkg::OP_SLL;
              FN_SRL:  alu_op = ex_pkg::OP_SRL;
              default: alu_op = ex_pkg::OP_SRA;
            endcase
          end
          default: writes = 1'b0;
        endcase
      end
      OPC_ADDI, OPC_ADDIU: begin
        imm_valid = 1'b1;
        writes    = 1'b1;
      end
      OPC_SLTI, OPC_SLTIU: begin
        alu_op      = ex_pkg::OP_SUB;
        alu_res_sel = ex_pkg::RES_SET;
        alu_set_u   = (opc == OPC_SLTIU);  // still sign-extended imm
        imm_valid   = 1'b1;
        writes      = 1'b1;
      end
      OPC_ANDI, OPC_ORI, OPC_XORI: begin
        sign_ext  = 1'b0;
        imm_valid = 1'b1;
        writes    = 1'b1;
        case (opc)
          OPC_ANDI: alu_op = ex_pkg::OP_AND;
          OPC_ORI:  alu_op = ex_pkg::OP_OR;
          default:  alu_op = ex_pkg::OP_XOR;
        endcase
      end
      OPC_LUI: begin
        alu_op    = ex_pkg::OP_LUI;
        imm_valid = 1'b1;
        writes    = 1'b1;
      end
      OPC_SW: begin
        imm_valid  = 1'b1;  // address = rs + imm
        store_inst = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- design/ex_pipe.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_pipe (
  input  logic               clock,
  input  logic               reset,
  input  logic [31:0]        instr,
  input  logic               instr_valid,
  output logic               wb_valid,
  output logic [`REG_AW-1:0] wb_reg,
  output logic [`XLEN-1:0]   wb_data,
  output logic               store_valid,
  output logic [`XLEN-1:0]   store_addr,
  output logic [`XLEN-1:0]   store_data
);

  // id stage
  logic [`REG_AW-1:0] rs, rt, dest_reg;
  logic               rs_used, dest_reg_valid, imm_valid, alu_set_u, store_inst;
  logic [`XLEN-1:0]   imm, rs_val, rt_val;
  logic [4:0]         shamt;
  ex_pkg::alu_op_t    alu_op;
  ex_pkg::res_sel_t   alu_res_sel;
  ex_pkg::fwd_t       a_fwd_from, b_fwd_from;

  // id/ex
  logic               idex_valid, idex_dest_valid, idex_store, idex_rs_used;
  logic               idex_imm_valid, idex_set_u;
  logic [`REG_AW-1:0] idex_dest;
  logic [`XLEN-1:0]   idex_a_val, idex_b_val, idex_imm;
  logic [4:0]         idex_shamt;
  ex_pkg::alu_op_t    idex_alu_op;
  ex_pkg::res_sel_t   idex_res_sel;
  ex_pkg::fwd_t       idex_a_fwd, idex_b_fwd;

  // ex/mem and mem/wb
  logic [`XLEN-1:0]   result, result_2;
  logic               exmem_valid, exmem_dest_valid, exmem_store;
  logic [`REG_AW-1:0] exmem_dest;
  logic [`XLEN-1:0]   exmem_result, exmem_result_2;
  logic               memwb_valid, memwb_dest_valid;
  logic [`REG_AW-1:0] memwb_dest;
  logic [`XLEN-1:0]   memwb_result;
  logic               wr_en;

  assign wr_en = memwb_valid & memwb_dest_valid;

  decode decode0 (
    .instr, .rs, .rt, .rs_used, .dest_reg, .dest_reg_valid, .imm, .imm_valid,
    .shamt, .alu_op, .alu_res_sel, .alu_set_u, .store_inst
  );

  regfile regfile0 (
    .clock, .reset, .rd_addr_a(rs), .rd_addr_b(rt), .rd_data_a(rs_val), .rd_data_b(rt_val),
    .wr_en, .wr_addr(memwb_dest), .wr_data(memwb_result)
  );

  fwd_unit fwd0 (
    .rs, .rt, .idex_dest, .idex_dest_valid(idex_valid & idex_dest_valid),
    .exmem_dest, .exmem_dest_valid(exmem_valid & exmem_dest_valid), .a_fwd_from, .b_fwd_from
  );

  ex ex0 (
    .a_val(idex_a_val), .b_val(idex_b_val), .result_from_ex_mem(exmem_result),
    .result_from_mem_wb(memwb_result), .a_fwd_from(idex_a_fwd), .b_fwd_from(idex_b_fwd),
    .a_reg_valid(idex_rs_used), .imm(idex_imm), .imm_valid(idex_imm_valid),
    .shamt(idex_shamt), .alu_op(idex_alu_op), .alu_res_sel(idex_res_sel),
    .alu_set_u(idex_set_u), .result, .result_2
  );

  // --------------------
  // stage valids
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      idex_valid  <= 1'b0;
      exmem_valid <= 1'b0;
      memwb_valid <= 1'b0;
      store_valid <= 1'b0;
      wb_valid    <= 1'b0;
    end else begin
      idex_valid  <= instr_valid;
      exmem_valid <= idex_valid;
      memwb_valid <= exmem_valid;
      store_valid <= exmem_valid & exmem_store;
      wb_valid    <= wr_en;   // same edge as the regfile write
    end
  end

  // --------------------
  // stage payload
  // --------------------
  always_ff @(posedge clock) begin
    idex_dest_valid  <= dest_reg_valid;
    idex_store       <= store_inst;
    idex_rs_used     <= rs_used;
    idex_imm_valid   <= imm_valid;
    idex_set_u       <= alu_set_u;
    idex_dest        <= dest_reg;
    idex_a_val       <= rs_val;
    idex_b_val       <= rt_val;
    idex_imm         <= imm;
    idex_shamt       <= shamt;
    idex_alu_op      <= alu_op;
    idex_res_sel     <= alu_res_sel;
    idex_a_fwd       <= a_fwd_from;   // chosen in id, used in ex
    idex_b_fwd       <= b_fwd_from;
    exmem_dest_valid <= idex_dest_valid;
    exmem_store      <= idex_store;
    exmem_dest       <= idex_dest;
    exmem_result     <= result;
    exmem_result_2   <= result_2;
    memwb_dest_valid <= exmem_dest_valid;   // mem just passes through
    memwb_dest       <= exmem_dest;
    memwb_result     <= exmem_result;
    store_addr       <= exmem_result;
    store_data       <= exmem_result_2;
    wb_reg           <= memwb_dest;
    wb_data          <= memwb_result;
  end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module regfile (
  input  logic               clock,
  input  logic               reset,
  input  logic [`REG_AW-1:0] rd_addr_a,
  input  logic [`REG_AW-1:0] rd_addr_b,
  output logic [`XLEN-1:0]   rd_data_a,
  output logic [`XLEN-1:0]   rd_data_b,
  input  logic               wr_en,
  input  logic [`REG_AW-1:0] wr_addr,
  input  logic [`XLEN-1:0]   wr_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // r0 reads zero, same-cycle write passes straight through
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr,
                                                 input logic               we,
                                                 input logic [`REG_AW-1:0] waddr,
                                                 input logic [`XLEN-1:0]   wdata,
                                                 input logic [`XLEN-1:0]   stored);
    if (addr == '0)
      return '0;
    else if (we && (waddr == addr))
      return wdata;
    else
      return stored;
  endfunction

  assign rd_data_a = read_port(rd_addr_a, wr_en, wr_addr, wr_data, regs[rd_addr_a]);
  assign rd_data_b = read_port(rd_addr_b, wr_en, wr_addr, wr_data, regs[rd_addr_b]);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

//--- ex/ex.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex (
  input  logic [`XLEN-1:0] a_val,
  input  logic [`XLEN-1:0] b_val,
  input  logic [`XLEN-1:0] result_from_ex_mem,
  input  logic [`XLEN-1:0] result_from_mem_wb,
  input  ex_pkg::fwd_t     a_fwd_from,
  input  ex_pkg::fwd_t     b_fwd_from,
  input  logic             a_reg_valid,
  input  logic [`XLEN-1:0] imm,
  input  logic             imm_valid,
  input  logic [4:0]       shamt,
  input  ex_pkg::alu_op_t  alu_op,
  input  ex_pkg::res_sel_t alu_res_sel,
  input  logic             alu_set_u,
  output logic [`XLEN-1:0] result,
  output logic [`XLEN-1:0] result_2
);

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] b_forwarded;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] set_res;
  logic [4:0]       shift_val;
  logic             flag_carry;   // borrow on subtract
  logic             overflow;
  logic             less;

  function automatic logic [`XLEN-1:0] fwd_mux(input ex_pkg::fwd_t     sel,
                                               input logic [`XLEN-1:0] reg_val,
                                               input logic [`XLEN-1:0] from_exmem,
                                               input logic [`XLEN-1:0] from_memwb);
    case (sel)
      ex_pkg::FWD_FROM_EXMEM: return from_exmem;
      ex_pkg::FWD_FROM_MEMWB: return from_memwb;
      default:                return reg_val;
    endcase
  endfunction

  // --------------------
  // operand select
  // --------------------
  assign a           = fwd_mux(a_fwd_from, a_val, result_from_ex_mem, result_from_mem_wb);
  assign b_forwarded = fwd_mux(b_fwd_from, b_val, result_from_ex_mem, result_from_mem_wb);
  assign b           = imm_valid ? imm : b_forwarded;
  assign result_2    = b_forwarded;   // store data

  // variable shifts take the amount from rs
  assign shift_val = a_reg_valid ? a[4:0] : shamt;

  // --------------------
  // alu
  // --------------------
  always_comb begin
    alu_res    = '0;
    flag_carry = 1'b0;
    case (alu_op)
      ex_pkg::OP_ADD:    {flag_carry, alu_res} = {1'b0, a} + {1'b0, b};
      ex_pkg::OP_SUB:    {flag_carry, alu_res} = {1'b0, a} - {1'b0, b};
      ex_pkg::OP_OR:     alu_res = a | b;
      ex_pkg::OP_XOR:    alu_res = a ^ b;
      ex_pkg::OP_NOR:    alu_res = ~(a | b);
      ex_pkg::OP_AND:    alu_res = a & b;
      ex_pkg::OP_SLL:    alu_res = b << shift_val;
      ex_pkg::OP_SRL:    alu_res = b >> shift_val;
      ex_pkg::OP_SRA:    alu_res = $signed(b) >>> shift_val;   // sign fill
      ex_pkg::OP_LUI:    alu_res = {b[15:0], 16'b0};
      ex_pkg::OP_PASS_A: alu_res = a;
      ex_pkg::OP_PASS_B: alu_res = b;
      default:           alu_res = '0;
    endcase
  end

  // --------------------
  // set-less-than
  // --------------------
  // relies on decode selecting OP_SUB for every set instruction
  assign overflow = (a[`XLEN-1] ^ b[`XLEN-1]) & (alu_res[`XLEN-1] ^ a[`XLEN-1]);
  assign less     = alu_set_u ? flag_carry : (alu_res[`XLEN-1] ^ overflow);
  assign set_res  = {{(`XLEN-1){1'b0}}, less};

  assign result = (alu_res_sel == ex_pkg::RES_ALU) ? alu_res : set_res;

endmodule

//--- ex/fwd_unit.sv
`timescale 1ns/1ps
`include "ex_defines.svh"

module fwd_unit (
  input  logic [`REG_AW-1:0] rs,
  input  logic [`REG_AW-1:0] rt,
  input  logic [`REG_AW-1:0] idex_dest,
  input  logic               idex_dest_valid,
  input  logic [`REG_AW-1:0] exmem_dest,
  input  logic               exmem_dest_valid,
  output ex_pkg::fwd_t       a_fwd_from,
  output ex_pkg::fwd_t       b_fwd_from
);

  // names are from the consumer's point of view once it sits in EX
  function automatic ex_pkg::fwd_t pick(input logic [`REG_AW-1:0] src,
                                        input logic [`REG_AW-1:0] near_dest,
                                        input logic               near_valid,
                                        input logic [`REG_AW-1:0] far_dest,
                                        input logic               far_valid);
    if (src == '0)
      return ex_pkg::FWD_NONE;
    else if (near_valid && (near_dest == src))
      return ex_pkg::FWD_FROM_EXMEM;   // youngest producer wins
    else if (far_valid && (far_dest == src))
      return ex_pkg::FWD_FROM_MEMWB;
    else
      return ex_pkg::FWD_NONE;
  endfunction

  assign a_fwd_from = pick(rs, idex_dest, idex_dest_valid, exmem_dest, exmem_dest_valid);
  assign b_fwd_from = pick(rt, idex_dest, idex_dest_valid, exmem_dest, exmem_dest_valid);

endmodule

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module tb_ex_pipe -o tb_ex_pipe

./obj_dir/tb_ex_pipe | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi

echo "simulation clean"

//--- verif/tb_ex_pipe.sv
`timescale 1ns/1ps

module tb_ex_pipe;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_INSTR    = 2000;
  // reset, issue, about one idle in eight, drain and headroom
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_INSTR + NUM_INSTR / 4 + 90;

  logic        clock;
  logic        reset;
  logic [31:0] instr;
  logic        instr_valid;
  logic        wb_valid;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;
  logic        store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;

  integer seed;
  int     errors;
  int     checks;
  int     issued;
  int     cycles = 0;

  logic [31:0] model_regs [32];

  // expected results in issue order
  logic [4:0]  wb_reg_q [$];
  logic [31:0] wb_data_q [$];
  string       wb_name_q [$];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  string       st_name_q [$];

  ex_pipe dut0 (
    .clock, .reset, .instr, .instr_valid, .wb_valid, .wb_reg, .wb_data,
    .store_valid, .store_addr, .store_data
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d write-backs and %0d stores never arrived",
               cycles, wb_reg_q.size(), st_addr_q.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  // --------------------
  // stimulus
  // --------------------
  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  function automatic logic [4:0] pick_reg();
    if (rand_below(8) == 0)
      return 5'(rand_below(32));
    else
      return 5'(rand_below(8));   // low regs, tight dependences
  endfunction

  function automatic logic [15:0] pick_imm();
    case (rand_below(8))
      0:       return 16'h8000;
      1:       return 16'h7fff;
      2:       return 16'hffff;
      3:       return 16'h0000;
      default: return 16'(rand_below(65536));
    endcase
  endfunction

  function automatic logic [5:0] r_funct(input int idx);
    case (idx)
      0:       return 6'h20;
      1:       return 6'h21;
      2:       return 6'h22;
      3:       return 6'h23;
      4:       return 6'h24;
      5:       return 6'h25;
      6:       return 6'h26;
      7:       return 6'h27;
      8:       return 6'h2a;
      9:       return 6'h2b;
      10:      return 6'h00;
      11:      return 6'h02;
      12:      return 6'h03;
      13:      return 6'h04;
      14:      return 6'h06;
      15:      return 6'h07;
      default: return 6'h01;   // not a valid funct
    endcase
  endfunction

  function automatic logic [5:0] i_opcode(input int idx);
    case (idx)
      0:       return 6'h08;
      1:       return 6'h09;
      2:       return 6'h0a;
      3:       return 6'h0b;
      4:       return 6'h0c;
      5:       return 6'h0d;
      6:       return 6'h0e;
      7:       return 6'h0f;
      8, 9:    return 6'h2b;
      10:      return 6'h04;   // beq, not supported
      default: return 6'h23;   // lw, not supported
    endcase
  endfunction

  function automatic logic [31:0] random_instr();
    int         k;
    logic [4:0] shamt;
    k = rand_below(29);
    shamt = (rand_below(4) == 0) ? 5'd31 : 5'(rand_below(32));
    if (k < 17)
      return {6'h00, pick_reg(), pick_reg(), pick_reg(), shamt, r_funct(k)};
    else
      return {i_opcode(k - 17), pick_reg(), pick_reg(), pick_imm()};
  endfunction

  // edge operands in r1..r3 before the random stream
  function automatic logic [31:0] seed_instr(input int idx);
    case (idx)
      0:       return {6'h0f, 5'd0, 5'd1, 16'h8000};
      1:       return {6'h0f, 5'd0, 5'd2, 16'h7fff};
      2:       return {6'h0d, 5'd2, 5'd2, 16'hffff};  // 0x7fffffff
      default: return {6'h09, 5'd0, 5'd3, 16'hffff};  // all ones
    endcase
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic string op_name(input logic [31:0] word);
    if (word[31:26] == 6'h00) begin
      case (word[5:0])
        6'h20:   return "add";
        6'h21:   return "addu";
        6'h22:   return "sub";
        6'h23:   return "subu";
        6'h24:   return "and";
        6'h25:   return "or";
        6'h26:   return "xor";
        6'h27:   return "nor";
        6'h2a:   return "slt";
        6'h2b:   return "sltu";
        6'h00:   return "sll";
        6'h02:   return "srl";
        6'h03:   return "sra";
        6'h04:   return "sllv";
        6'h06:   return "srlv";
        6'h07:   return "srav";
        default: return "unsupported";
      endcase
    end else begin
      case (word[31:26])
        6'h08:   return "addi";
        6'h09:   return "addiu";
        6'h0a:   return "slti";
        6'h0b:   return "sltiu";
        6'h0c:   return "andi";
        6'h0d:   return "ori";
        6'h0e:   return "xori";
        6'h0f:   return "lui";
        6'h2b:   return "sw";
        default: return "unsupported";
      endcase
    end
  endfunction

  task automatic predict(input logic [31:0] word);
    logic [5:0]  opc;
    logic [5:0]  funct;
    logic [4:0]  sh;
    logic [4:0]  dest;
    logic [15:0] imm16;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] res;
    string       name;
    opc   = word[31:26];
    funct = word[5:0];
    sh    = word[10:6];
    imm16 = word[15:0];
    a     = model_regs[word[25:21]];
    b     = model_regs[word[20:16]];
    simm  = {{16{imm16[15]}}, imm16};
    zimm  = {16'h0, imm16};
    name  = op_name(word);
    if (opc == 6'h00) begin
      dest = word[15:11];
      case (funct)
        6'h20, 6'h21: res = a + b;
        6'h22, 6'h23: res = a - b;
        6'h24:        res = a & b;
        6'h25:        res = a | b;
        6'h26:        res = a ^ b;
        6'h27:        res = ~(a | b);
        6'h2a:        res = {31'b0, $signed(a) < $signed(b)};
        6'h2b:        res = {31'b0, a < b};
        6'h00:        res = b << sh;
        6'h02:        res = b >> sh;
        6'h03:        res = $signed(b) >>> sh;
        6'h04:        res = b << a[4:0];
        6'h06:        res = b >> a[4:0];
        6'h07:        res = $signed(b) >>> a[4:0];
        default:      res = 32'h0;
      endcase
    end else begin
      dest = word[20:16];
      case (opc)
        6'h08, 6'h09: res = a + simm;
        6'h0a:        res = {31'b0, $signed(a) < $signed(simm)};
        6'h0b:        res = {31'b0, a < simm};   // unsigned, sign-extended imm
        6'h0c:        res = a & zimm;
        6'h0d:        res = a | zimm;
        6'h0e:        res = a ^ zimm;
        6'h0f:        res = {imm16, 16'h0};
        default:      res = 32'h0;
      endcase
    end
    if (name == "sw") begin
      st_addr_q.push_back(a + simm);
      st_data_q.push_back(b);
      st_name_q.push_back(name);
    end else if (name != "unsupported" && dest != 5'd0) begin
      wb_reg_q.push_back(dest);
      wb_data_q.push_back(res);
      wb_name_q.push_back(name);
      model_regs[dest] = res;
    end
  endtask

  // --------------------
  // checking
  // --------------------
  task automatic check_outputs();
    logic [4:0]  exp_reg;
    logic [31:0] exp_data;
    logic [31:0] exp_addr;
    string       name;
    if (wb_valid) begin
      if (wb_reg_q.size() == 0) begin
        $display("write-back of %08h to r%0d with no instruction pending", wb_data, wb_reg);
        errors++;
      end else begin
        exp_reg  = wb_reg_q.pop_front();
        exp_data = wb_data_q.pop_front();
        name     = wb_name_q.pop_front();
        checks++;
        if (wb_reg !== exp_reg || wb_data !== exp_data) begin
          $display("FAILED %s: expected r%0d = %08h, actual r%0d = %08h",
                   name, exp_reg, exp_data, wb_reg, wb_data);
          errors++;
        end
      end
    end
    if (store_valid) begin
      if (st_addr_q.size() == 0) begin
        $display("store to %08h with no store instruction pending", store_addr);
        errors++;
      end else begin
        exp_addr = st_addr_q.pop_front();
        exp_data = st_data_q.pop_front();
        name     = st_name_q.pop_front();
        checks++;
        if (store_addr !== exp_addr || store_data !== exp_data) begin
          $display("FAILED %s: expected [%08h] = %08h, actual [%08h] = %08h",
                   name, exp_addr, exp_data, store_addr, store_data);
          errors++;
        end
      end
    end
  endtask

  task automatic drive_next();
    logic [31:0] word;
    if (rand_below(8) == 0) begin
      instr_valid = 1'b0;
      instr       = $random(seed);   // junk, must be ignored
    end else begin
      if (issued < 4)
        word = seed_instr(issued);
      else
        word = random_instr();
      predict(word);
      instr       = word;
      instr_valid = 1'b1;
      issued++;
    end
  endtask

  initial begin
    seed        = 80;
    errors      = 0;
    checks      = 0;
    issued      = 0;
    reset       = 1'b1;
    instr       = 32'h0;
    instr_valid = 1'b0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = 32'h0;

    repeat (RESET_CYCLES) begin
      @(negedge clock);
      if (wb_valid !== 1'b0 || store_valid !== 1'b0) begin
        $display("strobe active during reset, wb_valid %b store_valid %b",
                 wb_valid, store_valid);
        errors++;
      end
    end
    reset = 1'b0;

    while (issued < NUM_INSTR) begin
      check_outputs();
      drive_next();
      @(negedge clock);
    end
    instr_valid = 1'b0;

    while (wb_reg_q.size() > 0 || st_addr_q.size() > 0) begin
      check_outputs();
      @(negedge clock);
    end
    repeat (4) begin   // stray strobes after drain
      check_outputs();
      @(negedge clock);
    end

    $display("%0d instructions, %0d checks, %0d errors", issued, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/ex_pkg.sv
design/decode.sv
design/regfile.sv
ex/fwd_unit.sv
ex/ex.sv
design/ex_pipe.sv
verif/tb_ex_pipe.sv
